// ==== common/mem_mon_settings.svh ====
`ifndef MEM_MON_SETTINGS_SVH
`define MEM_MON_SETTINGS_SVH

// depth and address width of the monitored memory
`define MM_NUMADDR 8192
`define MM_BITADDR 13

// user data word
`define MM_WIDTH 32

// number of user ports on each side
`define MM_NUMRDPT 2
`define MM_NUMWRPT 2

// cycles from a read request to its valid strobe
`define MM_READ_LAT 3

// width of the saturating error counter
`define MM_CNT_W 16

// byte address width of the register block
`define MM_APB_AW 8

`endif

// ==== common/mem_mon_pkg.sv ====
`default_nettype none

`include "mem_mon_settings.svh"

package mem_mon_pkg;

  typedef logic [`MM_BITADDR-1:0] addr_t;
  typedef logic [`MM_WIDTH-1:0] data_t;
  typedef logic [`MM_CNT_W-1:0] cnt_t;
  typedef logic [`MM_APB_AW-1:0] paddr_t;

  typedef struct packed {
    logic valid;
    addr_t addr;
    data_t data;
  } wr_port_t;

  typedef struct packed {
    logic valid;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic vld;
    data_t dout;
  } rd_rsp_t;

  // one bit per error class, same layout as the STATUS register
  typedef struct packed {
    logic rd_range;
    logic wr_range;
    logic missing_vld;
    logic spurious_vld;
    logic data_mismatch;
  } err_flags_t;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    paddr_t paddr;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    apb_idle,
    apb_setup,
    apb_access
  } apb_state_e;

endpackage

`default_nettype wire

// ==== logic/addr_range_check.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_mon_settings.svh"

module addr_range_check
  import mem_mon_pkg::*;
(
  input logic clk,
  input logic rst,
  input wr_port_t [`MM_NUMWRPT-1:0] wr,
  input rd_req_t [`MM_NUMRDPT-1:0] rd_req,
  output err_flags_t range_flags
);

  logic rd_bad;
  logic wr_bad;

  // any valid port whose address falls past the end of the memory
  always_comb begin
    rd_bad = 1'b0;
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      if (rd_req[p].valid && (32'(rd_req[p].addr) >= `MM_NUMADDR)) begin
        rd_bad = 1'b1;
      end
    end
  end

  always_comb begin
    wr_bad = 1'b0;
    for (int p = 0; p < `MM_NUMWRPT; p++) begin
      if (wr[p].valid && (32'(wr[p].addr) >= `MM_NUMADDR)) begin
        wr_bad = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      range_flags <= '0;
    end else begin
      range_flags <= '0;
      range_flags.rd_range <= rd_bad;
      range_flags.wr_range <= wr_bad;
    end
  end

  // the top level ORs this with the shadow checker, so foreign bits would alias
  a_range_bits_only: assert property (@(posedge clk) disable iff (rst)
    !(range_flags.missing_vld || range_flags.spurious_vld || range_flags.data_mismatch));

endmodule

`default_nettype wire

// ==== shadow/shadow_data_check.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_mon_settings.svh"

module shadow_data_check
  import mem_mon_pkg::*;
(
  input logic clk,
  input logic rst,
  input wr_port_t [`MM_NUMWRPT-1:0] wr,
  input rd_req_t [`MM_NUMRDPT-1:0] rd_req,
  input rd_rsp_t [`MM_NUMRDPT-1:0] rd_rsp,
  input addr_t sel_addr,
  output err_flags_t data_flags
);

  localparam int LAT = `MM_READ_LAT;

  addr_t trk_addr;
  logic shadow_vld;
  data_t shadow;

  logic [`MM_NUMWRPT-1:0] wr_hit;
  logic [`MM_NUMRDPT-1:0] rd_chk;

  // per read port, stage 0 is the youngest read
  logic [LAT-1:0] exp_pipe [`MM_NUMRDPT];
  logic [LAT-1:0] chk_pipe [`MM_NUMRDPT];
  data_t shd_pipe [`MM_NUMRDPT][LAT];

  logic miss_any;
  logic spur_any;
  logic mism_any;

  always_comb begin
    for (int p = 0; p < `MM_NUMWRPT; p++) begin
      wr_hit[p] = wr[p].valid && (wr[p].addr == trk_addr);
    end
  end

  // reads sample the shadow before this cycle's writes land
  always_comb begin
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      rd_chk[p] = rd_req[p].valid && (rd_req[p].addr == trk_addr) && shadow_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      trk_addr <= '0;
      shadow_vld <= 1'b0;
    end else if (sel_addr != trk_addr) begin
      trk_addr <= sel_addr;
      shadow_vld <= 1'b0;
    end else if (|wr_hit) begin
      shadow_vld <= 1'b1;
    end
  end

  // later ports override earlier ones, so port 1 wins a same-cycle collision
  always_ff @(posedge clk) begin
    for (int p = 0; p < `MM_NUMWRPT; p++) begin
      if (wr_hit[p]) begin
        shadow <= wr[p].data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        exp_pipe[p] <= '0;
        chk_pipe[p] <= '0;
      end
    end else begin
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        exp_pipe[p][0] <= rd_req[p].valid;
        chk_pipe[p][0] <= rd_chk[p];
        for (int k = 1; k < LAT; k++) begin
          exp_pipe[p][k] <= exp_pipe[p][k-1];
          chk_pipe[p][k] <= chk_pipe[p][k-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      shd_pipe[p][0] <= shadow;
      for (int k = 1; k < LAT; k++) begin
        shd_pipe[p][k] <= shd_pipe[p][k-1];
      end
    end
  end

  // the last stage lines up with the strobe of a read issued LAT cycles ago
  always_comb begin
    miss_any = 1'b0;
    spur_any = 1'b0;
    mism_any = 1'b0;
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      if (exp_pipe[p][LAT-1] && !rd_rsp[p].vld) begin
        miss_any = 1'b1;
      end
      if (!exp_pipe[p][LAT-1] && rd_rsp[p].vld) begin
        spur_any = 1'b1;
      end
      if (chk_pipe[p][LAT-1] && rd_rsp[p].vld &&
          (rd_rsp[p].dout != shd_pipe[p][LAT-1])) begin
        mism_any = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_flags <= '0;
    end else begin
      data_flags <= '0;
      data_flags.missing_vld <= miss_any;
      data_flags.spurious_vld <= spur_any;
      data_flags.data_mismatch <= mism_any;
    end
  end

  // the register block refuses out-of-range selects
  a_sel_in_range: assert property (@(posedge clk) disable iff (rst)
    32'(sel_addr) < `MM_NUMADDR);

endmodule

`default_nettype wire

// ==== logic/monitor_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_mon_settings.svh"

module monitor_csr
  import mem_mon_pkg::*;
(
  input logic clk,
  input logic rst,
  input err_flags_t flags,
  input apb_req_t apb_in,
  output apb_rsp_t apb_out,
  output addr_t sel_addr,
  output logic irq
);

  localparam paddr_t CTRL_ADDR = 'h00;
  localparam paddr_t SELECT_ADDR = 'h04;
  localparam paddr_t STATUS_ADDR = 'h08;
  localparam paddr_t COUNT_ADDR = 'h0C;
  localparam paddr_t FIRST_ADDR = 'h10;

  apb_state_e state;
  logic acc;
  logic wr_acc;
  logic mapped;
  logic sel_bad;

  logic chk_en;
  logic irq_en;
  err_flags_t flags_q;
  err_flags_t clr_mask;
  err_flags_t status;
  err_flags_t first;
  cnt_t count;
  logic hit;

  // tracks the phase of the previous cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= apb_idle;
    end else if (!apb_in.psel) begin
      state <= apb_idle;
    end else if (!apb_in.penable) begin
      state <= apb_setup;
    end else begin
      state <= apb_access;
    end
  end

  assign acc = apb_in.psel && apb_in.penable && (state == apb_setup);
  assign wr_acc = acc && apb_in.pwrite;
  assign sel_bad = apb_in.pwdata >= data_t'(`MM_NUMADDR);
  assign hit = (flags_q != '0);

  always_comb begin
    case (apb_in.paddr)
      CTRL_ADDR, SELECT_ADDR, STATUS_ADDR, COUNT_ADDR, FIRST_ADDR: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  always_comb begin
    apb_out = '0;
    apb_out.pready = apb_in.psel && apb_in.penable;
    if (acc) begin
      apb_out.pslverr = !mapped ||
                        (apb_in.pwrite && (apb_in.paddr == SELECT_ADDR) && sel_bad);
      if (!apb_in.pwrite) begin
        case (apb_in.paddr)
          CTRL_ADDR: apb_out.prdata = data_t'({irq_en, chk_en});
          SELECT_ADDR: apb_out.prdata = data_t'(sel_addr);
          STATUS_ADDR: apb_out.prdata = data_t'(status);
          COUNT_ADDR: apb_out.prdata = data_t'(count);
          FIRST_ADDR: apb_out.prdata = data_t'(first);
          default: apb_out.prdata = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_en <= 1'b0;
      irq_en <= 1'b0;
      sel_addr <= '0;
    end else if (wr_acc) begin
      if (apb_in.paddr == CTRL_ADDR) begin
        chk_en <= apb_in.pwdata[0];
        irq_en <= apb_in.pwdata[1];
      end
      // a refused select keeps the old address
      if ((apb_in.paddr == SELECT_ADDR) && !sel_bad) begin
        sel_addr <= apb_in.pwdata[`MM_BITADDR-1:0];
      end
    end
  end

  assign clr_mask = (wr_acc && (apb_in.paddr == STATUS_ADDR)) ?
                    apb_in.pwdata[$bits(err_flags_t)-1:0] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
      status <= '0;
      count <= '0;
      first <= '0;
      irq <= 1'b0;
    end else begin
      flags_q <= chk_en ? flags : '0;
      // a flag arriving with a clear stays set
      status <= (status & ~clr_mask) | flags_q;
      if (wr_acc && (apb_in.paddr == COUNT_ADDR)) begin
        count <= hit ? cnt_t'(1) : '0;
        first <= hit ? flags_q : '0;
      end else if (hit) begin
        if (count == '0) begin
          first <= flags_q;
        end
        if (count != '1) begin
          count <= count + cnt_t'(1);
        end
      end
      irq <= irq_en && (status != '0);
    end
  end

  a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
    apb_in.penable |-> apb_in.psel);

  a_access_after_setup: assert property (@(posedge clk) disable iff (rst)
    (apb_in.psel && apb_in.penable) |-> (state == apb_setup));

endmodule

`default_nettype wire

// ==== logic/mem_port_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_mon_settings.svh"

module mem_port_monitor
  import mem_mon_pkg::*;
(
  input logic clk,
  input logic rst,
  input wr_port_t [`MM_NUMWRPT-1:0] wr,
  input rd_req_t [`MM_NUMRDPT-1:0] rd_req,
  input rd_rsp_t [`MM_NUMRDPT-1:0] rd_rsp,
  input apb_req_t apb_in,
  output apb_rsp_t apb_out,
  output logic irq
);

  err_flags_t range_flags;
  err_flags_t data_flags;
  err_flags_t all_flags;
  addr_t sel_addr;

  // the two checkers own disjoint bits of the flag word
  assign all_flags = range_flags | data_flags;

  addr_range_check addr_range_check_inst (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr),
    .rd_req      (rd_req),
    .range_flags (range_flags)
  );

  shadow_data_check shadow_data_check_inst (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp),
    .sel_addr   (sel_addr),
    .data_flags (data_flags)
  );

  monitor_csr monitor_csr_inst (
    .clk      (clk),
    .rst      (rst),
    .flags    (all_flags),
    .apb_in   (apb_in),
    .apb_out  (apb_out),
    .sel_addr (sel_addr),
    .irq      (irq)
  );

endmodule

`default_nettype wire

// ==== sim/tb_mem_port_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_mon_settings.svh"

module tb_mem_port_monitor
  import mem_mon_pkg::*;
();

  localparam int LAT = `MM_READ_LAT;
  // the directed tests need about a thousand cycles, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam paddr_t R_CTRL = 8'h00;
  localparam paddr_t R_SELECT = 8'h04;
  localparam paddr_t R_STATUS = 8'h08;
  localparam paddr_t R_COUNT = 8'h0C;
  localparam paddr_t R_FIRST = 8'h10;
  localparam addr_t SEL_A = addr_t'(32'h123);

  logic clk;
  logic rst;
  wr_port_t [`MM_NUMWRPT-1:0] wr;
  rd_req_t [`MM_NUMRDPT-1:0] rd_req;
  rd_rsp_t [`MM_NUMRDPT-1:0] rd_rsp;
  apb_req_t apb_in;
  apb_rsp_t apb_out;
  logic irq;

  // fault knobs of the memory model, acting on the reads of the cycle they are set in
  logic drop_vld;
  logic corrupt_dout;
  logic extra_vld;
  logic keep_port0;

  data_t mem [`MM_NUMADDR];
  rd_rsp_t pipe [`MM_NUMRDPT][LAT];

  logic [31:0] rng;
  int cycles = 0;
  int errors;
  int test_errs;
  int tests_run;
  int tests_failed;
  string cur_test;

  mem_port_monitor mem_port_monitor_inst (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp),
    .apb_in  (apb_in),
    .apb_out (apb_out),
    .irq     (irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t fill_word(input int a);
    return data_t'(a) ^ (data_t'(a) << 16) ^ data_t'(32'h5a00_0000);
  endfunction

  function automatic data_t flag_word(input logic rd_r, input logic wr_r, input logic miss,
                                      input logic spur, input logic mism);
    err_flags_t f;
    f.rd_range = rd_r;
    f.wr_range = wr_r;
    f.missing_vld = miss;
    f.spurious_vld = spur;
    f.data_mismatch = mism;
    return data_t'(f);
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // behavioural memory, reads see the contents from before this cycle's writes
  always @(posedge clk) begin
    rd_rsp_t fresh;
    if (rst) begin
      for (int a = 0; a < `MM_NUMADDR; a++) begin
        mem[a] <= fill_word(a);
      end
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        for (int k = 0; k < LAT; k++) begin
          pipe[p][k] <= '0;
        end
      end
    end else begin
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        fresh.vld = rd_req[p].valid && !drop_vld;
        fresh.dout = '0;
        if (rd_req[p].valid && (32'(rd_req[p].addr) < `MM_NUMADDR)) begin
          fresh.dout = mem[rd_req[p].addr];
        end
        if (corrupt_dout) begin
          fresh.dout = fresh.dout ^ data_t'(1);
        end
        if ((p == 0) && extra_vld && !rd_req[p].valid) begin
          fresh.vld = 1'b1;
        end
        pipe[p][0] <= fresh;
        for (int k = 1; k < LAT; k++) begin
          pipe[p][k] <= pipe[p][k-1];
        end
      end
      // the port written last wins a collision, normally port 1
      for (int i = 0; i < `MM_NUMWRPT; i++) begin
        int w;
        w = keep_port0 ? (`MM_NUMWRPT - 1 - i) : i;
        if (wr[w].valid && (32'(wr[w].addr) < `MM_NUMADDR)) begin
          mem[wr[w].addr] <= wr[w].data;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `MM_NUMRDPT; p++) begin
      rd_rsp[p] = rst ? '0 : pipe[p][LAT-1];
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_ports();
    wr = '0;
    rd_req = '0;
    drop_vld = 1'b0;
    corrupt_dout = 1'b0;
    extra_vld = 1'b0;
  endtask

  // flags reach STATUS a fixed few cycles after the response slot
  task automatic drain();
    repeat (LAT + 4) @(posedge clk);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic report_mismatch(input string what, input data_t exp, input data_t act);
    $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    errors++;
    test_errs++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
    test_errs++;
  endtask

  task automatic apb_transfer(input logic write, input paddr_t a, input data_t wdata,
                              output data_t rdata, output logic err);
    int waits;
    waits = 0;
    next_cycle();
    apb_in.psel = 1'b1;
    apb_in.penable = 1'b0;
    apb_in.pwrite = write;
    apb_in.paddr = a;
    apb_in.pwdata = wdata;
    next_cycle();
    apb_in.penable = 1'b1;
    @(negedge clk);
    while (!apb_out.pready && (waits < 8)) begin
      @(negedge clk);
      waits++;
    end
    if (!apb_out.pready) begin
      report_problem("the APB access never saw pready");
    end
    rdata = apb_out.prdata;
    err = apb_out.pslverr;
    next_cycle();
    apb_in = '0;
  endtask

  task automatic write_reg(input string what, input paddr_t a, input data_t d,
                           input logic exp_err);
    data_t rdata;
    logic err;
    apb_transfer(1'b1, a, d, rdata, err);
    if (err !== exp_err) begin
      report_mismatch({what, " pslverr"}, data_t'(exp_err), data_t'(err));
    end
  endtask

  task automatic expect_reg(input string what, input paddr_t a, input data_t exp);
    data_t got;
    logic err;
    apb_transfer(1'b0, a, '0, got, err);
    if (err !== 1'b0) begin
      report_problem({what, " read returned pslverr"});
    end
    if (got !== exp) begin
      report_mismatch(what, exp, got);
    end
  endtask

  task automatic drive_writes(input logic en0, input logic en1, input addr_t a,
                              input data_t d0, input data_t d1);
    next_cycle();
    wr[0] = '{valid: en0, addr: a, data: d0};
    wr[1] = '{valid: en1, addr: a, data: d1};
    next_cycle();
    clear_ports();
  endtask

  task automatic drive_read(input int p, input addr_t a, input logic drop,
                            input logic corrupt);
    next_cycle();
    rd_req[p].valid = 1'b1;
    rd_req[p].addr = a;
    drop_vld = drop;
    corrupt_dout = corrupt;
    next_cycle();
    clear_ports();
  endtask

  task automatic inject_strobe();
    next_cycle();
    extra_vld = 1'b1;
    next_cycle();
    clear_ports();
  endtask

  task automatic check_irq(input logic exp);
    @(negedge clk);
    if (irq !== exp) begin
      report_mismatch("irq", data_t'(exp), data_t'(irq));
    end
  endtask

  initial begin
    int top;
    logic flag_exp;
    rst = 1'b1;
    apb_in = '0;
    keep_port0 = 1'b0;
    clear_ports();
    rng = 32'd4;
    errors = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("reset_values");
    check_irq(1'b0);
    expect_reg("CTRL", R_CTRL, '0);
    expect_reg("SELECT", R_SELECT, '0);
    expect_reg("STATUS", R_STATUS, '0);
    expect_reg("COUNT", R_COUNT, '0);
    expect_reg("FIRST", R_FIRST, '0);
    end_test();

    start_test("clean_traffic");
    write_reg("SELECT", R_SELECT, data_t'(SEL_A), 1'b0);
    write_reg("CTRL", R_CTRL, data_t'(1), 1'b0);
    drain();
    for (int c = 0; c < 200; c++) begin
      next_cycle();
      for (int p = 0; p < `MM_NUMWRPT; p++) begin
        rng = xorshift32(rng);
        wr[p].valid = rng[0];
        wr[p].addr = rng[1] ? SEL_A : addr_t'((rng >> 8) % 32'(`MM_NUMADDR));
        rng = xorshift32(rng);
        wr[p].data = data_t'(rng);
      end
      for (int p = 0; p < `MM_NUMRDPT; p++) begin
        rng = xorshift32(rng);
        rd_req[p].valid = rng[0];
        rd_req[p].addr = rng[1] ? SEL_A : addr_t'((rng >> 8) % 32'(`MM_NUMADDR));
      end
    end
    next_cycle();
    clear_ports();
    drain();
    expect_reg("STATUS", R_STATUS, '0);
    expect_reg("COUNT", R_COUNT, '0);
    end_test();

    start_test("data_mismatch");
    write_reg("CTRL", R_CTRL, data_t'(3), 1'b0);
    drive_writes(1'b1, 1'b0, SEL_A, data_t'(32'hcafe_0001), '0);
    drive_read(0, SEL_A, 1'b0, 1'b1);
    drain();
    expect_reg("STATUS", R_STATUS, flag_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    expect_reg("COUNT", R_COUNT, data_t'(1));
    expect_reg("FIRST", R_FIRST, flag_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    check_irq(1'b1);
    write_reg("STATUS", R_STATUS, flag_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), 1'b0);
    drain();
    expect_reg("STATUS", R_STATUS, '0);
    check_irq(1'b0);
    end_test();

    start_test("latency_errors");
    drive_read(1, addr_t'(5), 1'b1, 1'b0);
    drain();
    expect_reg("STATUS", R_STATUS, flag_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    write_reg("STATUS", R_STATUS, '1, 1'b0);
    inject_strobe();
    drain();
    expect_reg("STATUS", R_STATUS, flag_word(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
    write_reg("STATUS", R_STATUS, '1, 1'b0);
    end_test();

    start_test("address_range");
    // highest address a port can carry, past the end only if the depth leaves room
    top = (1 << `MM_BITADDR) - 1;
    flag_exp = (top >= `MM_NUMADDR);
    drive_writes(1'b0, 1'b1, addr_t'(top), '0, data_t'(32'h0bad_0bad));
    drain();
    expect_reg("STATUS", R_STATUS, flag_word(1'b0, flag_exp, 1'b0, 1'b0, 1'b0));
    write_reg("STATUS", R_STATUS, '1, 1'b0);
    drive_read(0, addr_t'(top), 1'b0, 1'b0);
    drain();
    expect_reg("STATUS", R_STATUS, flag_word(flag_exp, 1'b0, 1'b0, 1'b0, 1'b0));
    write_reg("STATUS", R_STATUS, '1, 1'b0);
    write_reg("SELECT", R_SELECT, data_t'(`MM_NUMADDR), 1'b1);
    expect_reg("SELECT", R_SELECT, data_t'(SEL_A));
    end_test();

    start_test("write_priority");
    drive_writes(1'b1, 1'b1, SEL_A, data_t'(32'h1111_0000), data_t'(32'h2222_0001));
    drive_read(1, SEL_A, 1'b0, 1'b0);
    drain();
    expect_reg("STATUS", R_STATUS, '0);
    keep_port0 = 1'b1;
    drive_writes(1'b1, 1'b1, SEL_A, data_t'(32'h3333_0002), data_t'(32'h4444_0003));
    drive_read(1, SEL_A, 1'b0, 1'b0);
    drain();
    expect_reg("STATUS", R_STATUS, flag_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    keep_port0 = 1'b0;
    write_reg("STATUS", R_STATUS, '1, 1'b0);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/mem_mon_pkg.sv
logic/addr_range_check.sv
shadow/shadow_data_check.sv
logic/monitor_csr.sv
logic/mem_port_monitor.sv
sim/tb_mem_port_monitor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mem_port_monitor
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
